// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module pipelineTb -Mdir obj_dir -f filelist.f
	./obj_dir/VpipelineTb

clean:
	rm -rf obj_dir

// ==== common/pipelinePkg.sv ====
`include "pipeline_settings.svh"

package pipelinePkg;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b,
        OP_HALT  = 6'h3f
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2a
    } func_e;

    // ----------------------------------------
    // instruction formats
    // ----------------------------------------
    typedef struct packed {
        opcode_e                opcode;
        logic [`PIPE_REG_W-1:0] rs;
        logic [`PIPE_REG_W-1:0] rt;
        logic [`PIPE_REG_W-1:0] rd;
        logic [4:0]             shamt;  // not used by this core
        func_e                  func;
    } rType_t;

    typedef struct packed {
        opcode_e                opcode;
        logic [`PIPE_REG_W-1:0] rs;
        logic [`PIPE_REG_W-1:0] rt;
        logic [15:0]            imm;
    } iType_t;

    typedef union packed {
        rType_t rType;
        iType_t iType;
    } instrWord_u;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } aluOp_e;

    typedef struct packed {
        logic   regWrite;
        logic   mem2reg;    // write back load data
        logic   memRead;
        logic   memWrite;
        logic   aluSrcImm;  // operand B from immediate
        logic   regDst;     // rd instead of rt
        aluOp_e aluOp;
        logic   halt;
    } ctrlFlags_t;

    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,
        FWD_WB
    } fwdSel_e;

    // ----------------------------------------
    // stage registers
    // ----------------------------------------
    typedef struct packed {
        ctrlFlags_t              ctrl;
        logic [`PIPE_DATA_W-1:0] opA;
        logic [`PIPE_DATA_W-1:0] opB;
        logic [`PIPE_DATA_W-1:0] imm;
        logic [`PIPE_REG_W-1:0]  rs;
        logic [`PIPE_REG_W-1:0]  rt;
        logic [`PIPE_REG_W-1:0]  dest;
    } idExBus_t;

    typedef struct packed {
        ctrlFlags_t              ctrl;
        logic [`PIPE_DATA_W-1:0] aluResult;
        logic [`PIPE_DATA_W-1:0] storeData;
        logic [`PIPE_REG_W-1:0]  dest;
    } exMemBus_t;

    typedef struct packed {
        logic                    valid;
        logic [`PIPE_REG_W-1:0]  dest;
        logic [`PIPE_DATA_W-1:0] data;
    } wbBus_t;

endpackage

// ==== common/pipeline_settings.svh ====
`ifndef PIPELINE_SETTINGS_SVH
`define PIPELINE_SETTINGS_SVH

// ----------------------------------------
// datapath sizes
// ----------------------------------------

// data word width
`define PIPE_DATA_W 32

// register address, 32 registers
`define PIPE_REG_W 5

// instruction memory, word addressed
`define PIPE_IMEM_WORDS 64

// data memory, byte address with the low two bits dropped
`define PIPE_DMEM_WORDS 64

`endif

// ==== design/decodeStage.sv ====
`timescale 1ns/10ps
`include "pipeline_settings.svh"

module decodeStage (
    input  logic                    clk,
    input  logic                    i_reset,
    input  pipelinePkg::instrWord_u i_ifId,
    input  logic                    i_ifIdValid,
    input  pipelinePkg::ctrlFlags_t i_ctrl,
    input  logic                    i_stall,
    input  pipelinePkg::wbBus_t     i_writeBack,
    output pipelinePkg::idExBus_t   o_idEx
);

    localparam int numRegs = 2 ** `PIPE_REG_W;

    logic [`PIPE_DATA_W-1:0] regFile [numRegs];
    logic [`PIPE_REG_W-1:0]  rs;
    logic [`PIPE_REG_W-1:0]  rt;
    logic [`PIPE_DATA_W-1:0] dataA;
    logic [`PIPE_DATA_W-1:0] dataB;
    logic [`PIPE_DATA_W-1:0] immExt;
    logic [`PIPE_REG_W-1:0]  dest;

    assign rs = i_ifId.rType.rs;
    assign rt = i_ifId.rType.rt;

    // write port, valid is never set for r0
    always_ff @(posedge clk) begin
        if (i_writeBack.valid)
            regFile[i_writeBack.dest] <= i_writeBack.data;
    end

    // ----------------------------------------
    // operand read with write-through
    // ----------------------------------------
    always_comb begin
        if (rs == '0)
            dataA = '0;
        else if (i_writeBack.valid && i_writeBack.dest == rs)
            dataA = i_writeBack.data;
        else
            dataA = regFile[rs];

        if (rt == '0)
            dataB = '0;
        else if (i_writeBack.valid && i_writeBack.dest == rt)
            dataB = i_writeBack.data;
        else
            dataB = regFile[rt];
    end

    assign immExt = {{(`PIPE_DATA_W - 16){i_ifId.iType.imm[15]}}, i_ifId.iType.imm};
    assign dest   = i_ctrl.regDst ? i_ifId.rType.rd : rt;   // rd only for R-type

    // ID/EX, flags cleared for a bubble
    always_ff @(posedge clk) begin
        if (i_reset || i_stall || !i_ifIdValid)
            o_idEx.ctrl <= '0;
        else
            o_idEx.ctrl <= i_ctrl;
    end

    always_ff @(posedge clk) begin
        o_idEx.opA  <= dataA;
        o_idEx.opB  <= dataB;
        o_idEx.imm  <= immExt;
        o_idEx.rs   <= rs;
        o_idEx.rt   <= rt;
        o_idEx.dest <= dest;
    end

endmodule

// ==== design/executeStage.sv ====
`timescale 1ns/10ps
`include "pipeline_settings.svh"

module executeStage (
    input  logic                    clk,
    input  logic                    i_reset,
    input  pipelinePkg::idExBus_t   i_idEx,
    input  pipelinePkg::fwdSel_e    i_fwdA,
    input  pipelinePkg::fwdSel_e    i_fwdB,
    input  logic [`PIPE_DATA_W-1:0] i_exMemResult,
    input  pipelinePkg::wbBus_t     i_writeBack,
    output pipelinePkg::exMemBus_t  o_exMem
);

    logic [`PIPE_DATA_W-1:0] srcA;
    logic [`PIPE_DATA_W-1:0] srcB;
    logic [`PIPE_DATA_W-1:0] aluB;
    logic [`PIPE_DATA_W-1:0] result;

    // ----------------------------------------
    // operand forwarding
    // ----------------------------------------
    always_comb begin
        case (i_fwdA)
            pipelinePkg::FWD_MEM: srcA = i_exMemResult;
            pipelinePkg::FWD_WB:  srcA = i_writeBack.data;
            default:              srcA = i_idEx.opA;
        endcase
        case (i_fwdB)
            pipelinePkg::FWD_MEM: srcB = i_exMemResult;
            pipelinePkg::FWD_WB:  srcB = i_writeBack.data;
            default:              srcB = i_idEx.opB;
        endcase
    end

    assign aluB = i_idEx.ctrl.aluSrcImm ? i_idEx.imm : srcB;

    always_comb begin
        case (i_idEx.ctrl.aluOp)
            pipelinePkg::ALU_SUB: result = srcA - aluB;
            pipelinePkg::ALU_AND: result = srcA & aluB;
            pipelinePkg::ALU_OR:  result = srcA | aluB;
            pipelinePkg::ALU_SLT: result = {{(`PIPE_DATA_W - 1){1'b0}},
                                            $signed(srcA) < $signed(aluB)};
            default:              result = srcA + aluB;  // add, also address calc
        endcase
    end

    // EX/MEM
    always_ff @(posedge clk) begin
        if (i_reset)
            o_exMem.ctrl <= '0;
        else
            o_exMem.ctrl <= i_idEx.ctrl;
    end

    always_ff @(posedge clk) begin
        o_exMem.aluResult <= result;
        o_exMem.storeData <= srcB;  // forwarded rt for stores
        o_exMem.dest      <= i_idEx.dest;
    end

endmodule

// ==== design/fetchStage.sv ====
`timescale 1ns/10ps
`include "pipeline_settings.svh"

module fetchStage (
    input  logic                                clk,
    input  logic                                i_reset,
    input  logic                                i_we_IF,
    input  logic [$clog2(`PIPE_IMEM_WORDS)-1:0] i_instAddr,
    input  logic [`PIPE_DATA_W-1:0]             i_instructionData,
    input  logic                                i_stall,
    input  logic                                i_halted,
    output pipelinePkg::instrWord_u             o_ifId,
    output logic                                o_ifIdValid
);

    localparam int addrW = $clog2(`PIPE_IMEM_WORDS);

    logic [`PIPE_DATA_W-1:0] instMem [`PIPE_IMEM_WORDS];
    logic [addrW-1:0]        pc;
    logic                    advance;

    assign advance = !i_we_IF && !i_halted && !i_stall;

    // program load port
    always_ff @(posedge clk) begin
        if (i_we_IF)
            instMem[i_instAddr] <= i_instructionData;
    end

    // ----------------------------------------
    // pc and IF/ID
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (i_reset) begin
            pc          <= '0;
            o_ifIdValid <= 1'b0;
        end else if (i_we_IF) begin
            pc          <= '0;  // restart from word 0 after loading
            o_ifIdValid <= 1'b0;
        end else if (i_halted) begin
            o_ifIdValid <= 1'b0;
        end else if (!i_stall) begin
            pc          <= pc + addrW'(1);
            o_ifIdValid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (advance)
            o_ifId <= instMem[pc];
    end

endmodule

// ==== design/memoryStage.sv ====
`timescale 1ns/10ps
`include "pipeline_settings.svh"

module memoryStage (
    input  logic                    clk,
    input  logic                    i_reset,
    input  pipelinePkg::exMemBus_t  i_exMem,
    output pipelinePkg::wbBus_t     o_writeBack,
    output logic                    o_memWrite,
    output logic [7:0]              o_dataAddr,
    output logic [`PIPE_DATA_W-1:0] o_data2mem,
    output logic                    o_end
);

    localparam int wordW = $clog2(`PIPE_DMEM_WORDS);

    logic [`PIPE_DATA_W-1:0] dataMem [`PIPE_DMEM_WORDS];
    logic [wordW-1:0]        wordIdx;
    logic [`PIPE_DATA_W-1:0] loadData;

    // MEM/WB contents
    logic                    wbValid;
    logic                    wbMem2reg;
    logic [`PIPE_REG_W-1:0]  wbDest;
    logic [`PIPE_DATA_W-1:0] wbLoad;
    logic [`PIPE_DATA_W-1:0] wbAlu;

    assign wordIdx  = i_exMem.aluResult[wordW+1:2];   // byte offset ignored
    assign loadData = dataMem[wordIdx];

    always_ff @(posedge clk) begin
        if (i_exMem.ctrl.memWrite)
            dataMem[wordIdx] <= i_exMem.storeData;
    end

    // store bus, visible in the write cycle
    assign o_memWrite = i_exMem.ctrl.memWrite;
    assign o_dataAddr = i_exMem.aluResult[7:0];
    assign o_data2mem = i_exMem.storeData;

    // ----------------------------------------
    // MEM/WB register and end flag
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (i_reset) begin
            wbValid <= 1'b0;
            o_end   <= 1'b0;
        end else begin
            wbValid <= i_exMem.ctrl.regWrite && (i_exMem.dest != '0);
            if (i_exMem.ctrl.halt)
                o_end <= 1'b1;  // held until reset
        end
    end

    always_ff @(posedge clk) begin
        wbMem2reg <= i_exMem.ctrl.mem2reg;
        wbDest    <= i_exMem.dest;
        wbLoad    <= loadData;
        wbAlu     <= i_exMem.aluResult;
    end

    assign o_writeBack.valid = wbValid;
    assign o_writeBack.dest  = wbDest;
    assign o_writeBack.data  = wbMem2reg ? wbLoad : wbAlu;

endmodule

// ==== design/pipelineControl.sv ====
`timescale 1ns/10ps
`include "pipeline_settings.svh"

module pipelineControl (
    input  logic                    clk,
    input  logic                    i_reset,
    input  pipelinePkg::instrWord_u i_ifId,
    input  logic                    i_ifIdValid,
    input  pipelinePkg::idExBus_t   i_idEx,
    input  pipelinePkg::exMemBus_t  i_exMem,
    input  pipelinePkg::wbBus_t     i_writeBack,
    output pipelinePkg::ctrlFlags_t o_ctrl,
    output logic                    o_stall,
    output pipelinePkg::fwdSel_e    o_fwdA,
    output pipelinePkg::fwdSel_e    o_fwdB,
    output logic                    o_halted
);

    logic usesRs;
    logic usesRt;
    logic loadHazard;
    logic memFwdOk;
    logic haltSeen;

    // ----------------------------------------
    // instruction decode
    // ----------------------------------------
    always_comb begin
        o_ctrl = '0;    // unknown opcode runs as a nop
        usesRs = 1'b0;
        usesRt = 1'b0;
        if (i_ifIdValid) begin
            case (i_ifId.rType.opcode)
                pipelinePkg::OP_RTYPE: begin
                    usesRs = 1'b1;
                    usesRt = 1'b1;
                    o_ctrl.regDst = 1'b1;
                    o_ctrl.regWrite = 1'b1;
                    case (i_ifId.rType.func)
                        pipelinePkg::FN_ADD: o_ctrl.aluOp = pipelinePkg::ALU_ADD;
                        pipelinePkg::FN_SUB: o_ctrl.aluOp = pipelinePkg::ALU_SUB;
                        pipelinePkg::FN_AND: o_ctrl.aluOp = pipelinePkg::ALU_AND;
                        pipelinePkg::FN_OR:  o_ctrl.aluOp = pipelinePkg::ALU_OR;
                        pipelinePkg::FN_SLT: o_ctrl.aluOp = pipelinePkg::ALU_SLT;
                        default:             o_ctrl.regWrite = 1'b0;  // bad func
                    endcase
                end
                pipelinePkg::OP_ADDI: begin
                    usesRs = 1'b1;
                    o_ctrl.regWrite = 1'b1;
                    o_ctrl.aluSrcImm = 1'b1;
                end
                pipelinePkg::OP_LW: begin
                    usesRs = 1'b1;
                    o_ctrl.regWrite = 1'b1;
                    o_ctrl.mem2reg = 1'b1;
                    o_ctrl.memRead = 1'b1;
                    o_ctrl.aluSrcImm = 1'b1;
                end
                pipelinePkg::OP_SW: begin
                    usesRs = 1'b1;
                    usesRt = 1'b1;  // store data
                    o_ctrl.memWrite = 1'b1;
                    o_ctrl.aluSrcImm = 1'b1;
                end
                pipelinePkg::OP_HALT: o_ctrl.halt = 1'b1;
                default: ;
            endcase
        end
    end

    // load in EX feeding the instruction in ID
    assign loadHazard = i_idEx.ctrl.memRead && (i_idEx.dest != '0) &&
                        ((usesRs && i_idEx.dest == i_ifId.rType.rs) ||
                         (usesRt && i_idEx.dest == i_ifId.rType.rt));
    assign o_stall = loadHazard;

    // ----------------------------------------
    // forwarding, EX/MEM wins over MEM/WB
    // ----------------------------------------
    assign memFwdOk = i_exMem.ctrl.regWrite && (i_exMem.dest != '0);

    always_comb begin
        o_fwdA = pipelinePkg::FWD_NONE;
        o_fwdB = pipelinePkg::FWD_NONE;
        if (memFwdOk && i_exMem.dest == i_idEx.rs)
            o_fwdA = pipelinePkg::FWD_MEM;
        else if (i_writeBack.valid && i_writeBack.dest == i_idEx.rs)
            o_fwdA = pipelinePkg::FWD_WB;
        if (memFwdOk && i_exMem.dest == i_idEx.rt)
            o_fwdB = pipelinePkg::FWD_MEM;
        else if (i_writeBack.valid && i_writeBack.dest == i_idEx.rt)
            o_fwdB = pipelinePkg::FWD_WB;
    end

    // sticky once a halt leaves decode
    always_ff @(posedge clk) begin
        if (i_reset)
            haltSeen <= 1'b0;
        else if (o_ctrl.halt && !o_stall)
            haltSeen <= 1'b1;
    end

    assign o_halted = haltSeen | o_ctrl.halt;   // stop fetch in the same cycle

endmodule

// ==== design/pipelineTop.sv ====
`timescale 1ns/10ps
`include "pipeline_settings.svh"

module pipelineTop (
    input  logic                                clk,
    input  logic                                i_reset,
    input  logic                                i_we_IF,
    input  logic [$clog2(`PIPE_IMEM_WORDS)-1:0] i_instAddr,
    input  logic [`PIPE_DATA_W-1:0]             i_instructionData,
    output pipelinePkg::wbBus_t                 o_writeBack,
    output logic                                o_memWrite,
    output logic [7:0]                          o_dataAddr,
    output logic [`PIPE_DATA_W-1:0]             o_data2mem,
    output logic                                o_end
);

    pipelinePkg::instrWord_u ifId;
    logic                    ifIdValid;
    pipelinePkg::ctrlFlags_t ctrl;
    logic                    stall;
    logic                    halted;
    pipelinePkg::fwdSel_e    fwdA;
    pipelinePkg::fwdSel_e    fwdB;
    pipelinePkg::idExBus_t   idEx;
    pipelinePkg::exMemBus_t  exMem;
    pipelinePkg::wbBus_t     writeBack;

    pipelineControl u_control (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_ifId      (ifId),
        .i_ifIdValid (ifIdValid),
        .i_idEx      (idEx),
        .i_exMem     (exMem),
        .i_writeBack (writeBack),
        .o_ctrl      (ctrl),
        .o_stall     (stall),
        .o_fwdA      (fwdA),
        .o_fwdB      (fwdB),
        .o_halted    (halted)
    );

    fetchStage u_fetch (
        .clk               (clk),
        .i_reset           (i_reset),
        .i_we_IF           (i_we_IF),
        .i_instAddr        (i_instAddr),
        .i_instructionData (i_instructionData),
        .i_stall           (stall),
        .i_halted          (halted),
        .o_ifId            (ifId),
        .o_ifIdValid       (ifIdValid)
    );

    decodeStage u_decode (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_ifId      (ifId),
        .i_ifIdValid (ifIdValid),
        .i_ctrl      (ctrl),
        .i_stall     (stall),
        .i_writeBack (writeBack),
        .o_idEx      (idEx)
    );

    executeStage u_execute (
        .clk           (clk),
        .i_reset       (i_reset),
        .i_idEx        (idEx),
        .i_fwdA        (fwdA),
        .i_fwdB        (fwdB),
        .i_exMemResult (exMem.aluResult),   // EX/MEM forward path
        .i_writeBack   (writeBack),
        .o_exMem       (exMem)
    );

    memoryStage u_memory (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_exMem     (exMem),
        .o_writeBack (writeBack),
        .o_memWrite  (o_memWrite),
        .o_dataAddr  (o_dataAddr),
        .o_data2mem  (o_data2mem),
        .o_end       (o_end)
    );

    assign o_writeBack = writeBack;

endmodule

// ==== filelist.f ====
+incdir+common
common/pipelinePkg.sv
design/pipelineControl.sv
design/fetchStage.sv
design/decodeStage.sv
design/executeStage.sv
design/memoryStage.sv
design/pipelineTop.sv
tb/pipelineTb.sv

// ==== tb/pipelineTb.sv ====
`timescale 1ns/10ps
`include "pipeline_settings.svh"

module pipelineTb;

    typedef struct packed {
        logic [`PIPE_REG_W-1:0]  dest;
        logic [`PIPE_DATA_W-1:0] data;
        logic [7:0]              idx;   // instruction number
    } expWrite_t;

    typedef struct packed {
        logic [7:0]              addr;
        logic [`PIPE_DATA_W-1:0] data;
        logic [7:0]              idx;
    } expStore_t;

    logic                                clk;
    logic                                i_reset;
    logic                                i_we_IF;
    logic [$clog2(`PIPE_IMEM_WORDS)-1:0] i_instAddr;
    logic [`PIPE_DATA_W-1:0]             i_instructionData;
    pipelinePkg::wbBus_t                 o_writeBack;
    logic                                o_memWrite;
    logic [7:0]                          o_dataAddr;
    logic [`PIPE_DATA_W-1:0]             o_data2mem;
    logic                                o_end;

    integer                  seed = 32'h32c1;
    int                      watchCycles = 0;
    logic                    endSeen = 1'b0;
    string                   curTest;
    logic [`PIPE_DATA_W-1:0] prog[$];
    string                   testOf[$];     // test name per instruction
    expWrite_t               expWrites[$];
    expStore_t               expStores[$];
    logic [`PIPE_DATA_W-1:0] refRegs [32];
    logic [`PIPE_DATA_W-1:0] refMem [`PIPE_DMEM_WORDS];

    pipelineTop dut (
        .clk               (clk),
        .i_reset           (i_reset),
        .i_we_IF           (i_we_IF),
        .i_instAddr        (i_instAddr),
        .i_instructionData (i_instructionData),
        .o_writeBack       (o_writeBack),
        .o_memWrite        (o_memWrite),
        .o_dataAddr        (o_dataAddr),
        .o_data2mem        (o_data2mem),
        .o_end             (o_end)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stopRun(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    function automatic logic [15:0] randImm();
        logic [31:0] r;
        r = $random(seed);
        return r[15:0];
    endfunction

    // ----------------------------------------
    // reference model that runs while assembling
    // ----------------------------------------
    task automatic recordWrite(input int rd, input logic [`PIPE_DATA_W-1:0] value);
        expWrite_t e;
        if (rd != 0) begin     // r0 never shows up on the bus
            refRegs[rd] = value;
            e.dest = rd[4:0];
            e.data = value;
            e.idx  = 8'(prog.size());
            expWrites.push_back(e);
        end
    endtask

    task automatic emitR(input pipelinePkg::func_e fn, input int rd, input int rs, input int rt);
        pipelinePkg::instrWord_u w;
        logic [`PIPE_DATA_W-1:0] a;
        logic [`PIPE_DATA_W-1:0] b;
        logic [`PIPE_DATA_W-1:0] res;
        a = refRegs[rs];
        b = refRegs[rt];
        case (fn)
            pipelinePkg::FN_SUB: res = a - b;
            pipelinePkg::FN_AND: res = a & b;
            pipelinePkg::FN_OR:  res = a | b;
            pipelinePkg::FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:             res = a + b;
        endcase
        w.rType.opcode = pipelinePkg::OP_RTYPE;
        w.rType.rs     = rs[4:0];
        w.rType.rt     = rt[4:0];
        w.rType.rd     = rd[4:0];
        w.rType.shamt  = '0;
        w.rType.func   = fn;
        recordWrite(rd, res);
        testOf.push_back(curTest);
        prog.push_back(w);
    endtask

    // operand order as in "addi rt, rs, imm"
    task automatic emitI(input pipelinePkg::opcode_e op, input int rt, input int rs,
                         input logic [15:0] imm);
        pipelinePkg::instrWord_u w;
        logic [`PIPE_DATA_W-1:0] addr;
        expStore_t               s;
        addr = refRegs[rs] + {{16{imm[15]}}, imm};
        case (op)
            pipelinePkg::OP_ADDI: recordWrite(rt, addr);
            pipelinePkg::OP_LW:   recordWrite(rt, refMem[addr[7:2]]);
            pipelinePkg::OP_SW: begin
                s.addr = addr[7:0];
                s.data = refRegs[rt];
                s.idx  = 8'(prog.size());
                expStores.push_back(s);
                refMem[addr[7:2]] = refRegs[rt];
            end
            default: ;
        endcase
        w.iType.opcode = op;
        w.iType.rs     = rs[4:0];
        w.iType.rt     = rt[4:0];
        w.iType.imm    = imm;
        testOf.push_back(curTest);
        prog.push_back(w);
    endtask

    task automatic buildProgram();
        logic [31:0] r;
        for (int k = 0; k < 32; k++)
            refRegs[k] = '0;
        curTest = "alu_ops";
        emitI(pipelinePkg::OP_ADDI, 1, 0, randImm());
        emitI(pipelinePkg::OP_ADDI, 2, 0, randImm());
        emitI(pipelinePkg::OP_ADDI, 3, 1, randImm());
        emitR(pipelinePkg::FN_ADD, 4, 1, 2);
        emitR(pipelinePkg::FN_SUB, 5, 1, 2);
        emitR(pipelinePkg::FN_AND, 6, 1, 2);
        emitR(pipelinePkg::FN_OR,  7, 1, 2);
        emitR(pipelinePkg::FN_SLT, 8, 1, 2);
        emitR(pipelinePkg::FN_SLT, 9, 2, 1);
        curTest = "forwarding";
        emitI(pipelinePkg::OP_ADDI, 10, 0, randImm());
        emitR(pipelinePkg::FN_ADD, 11, 10, 10);    // distance 1
        emitR(pipelinePkg::FN_SUB, 12, 11, 10);    // distances 1 and 2
        emitI(pipelinePkg::OP_ADDI, 15, 0, randImm());
        emitI(pipelinePkg::OP_ADDI, 16, 0, randImm());
        emitI(pipelinePkg::OP_ADDI, 17, 0, randImm());
        emitR(pipelinePkg::FN_ADD, 18, 15, 16);    // distances 3 and 2
        emitR(pipelinePkg::FN_OR,  19, 17, 18);
        curTest = "load_use";
        r = $random(seed);
        emitI(pipelinePkg::OP_ADDI, 20, 0, {9'b0, r[4:0], 2'b00});
        emitI(pipelinePkg::OP_SW, 19, 20, 16'h0);
        emitI(pipelinePkg::OP_LW, 21, 20, 16'h0);
        emitR(pipelinePkg::FN_ADD, 22, 21, 1);     // stall on rs
        emitI(pipelinePkg::OP_SW, 22, 20, 16'h4);
        emitI(pipelinePkg::OP_LW, 24, 20, 16'h4);
        emitR(pipelinePkg::FN_SUB, 25, 1, 24);     // stall on rt
        curTest = "reg_zero";
        emitI(pipelinePkg::OP_ADDI, 0, 1, randImm());
        emitR(pipelinePkg::FN_ADD, 0, 1, 2);
        emitR(pipelinePkg::FN_ADD, 26, 0, 3);
        emitR(pipelinePkg::FN_OR,  27, 0, 0);
        curTest = "halt";
        emitI(pipelinePkg::OP_HALT, 0, 0, 16'h0);
    endtask

    // ----------------------------------------
    // output checks sampled mid cycle
    // ----------------------------------------
    always @(negedge clk) begin
        expWrite_t wbHead;
        expStore_t stHead;
        if (!i_reset && o_writeBack.valid === 1'b1) begin
            assert (expWrites.size() > 0)
                else stopRun("write-back seen when no register write was expected");
            wbHead = expWrites.pop_front();
            assert (o_writeBack.dest == wbHead.dest && o_writeBack.data == wbHead.data)
                else stopRun($sformatf("[FAIL] %s: expected r%0d=%h, actual r%0d=%h",
                    testOf[wbHead.idx], wbHead.dest, wbHead.data,
                    o_writeBack.dest, o_writeBack.data));
        end
        if (!i_reset && o_memWrite === 1'b1) begin
            assert (expStores.size() > 0)
                else stopRun("store seen when no store was expected");
            stHead = expStores.pop_front();
            assert (o_dataAddr == stHead.addr && o_data2mem == stHead.data)
                else stopRun($sformatf("[FAIL] %s: expected mem[%h]=%h, actual mem[%h]=%h",
                    testOf[stHead.idx], stHead.addr, stHead.data, o_dataAddr, o_data2mem));
        end
        if (!i_reset && o_end === 1'b1 && !endSeen) begin
            endSeen = 1'b1;
            assert (expWrites.size() == 0 && expStores.size() == 0)
                else stopRun($sformatf("end flag rose with %0d writes and %0d stores missing",
                    expWrites.size(), expStores.size()));
        end
    end

    // runaway guard
    initial begin
        wait (watchCycles > 0);
        #(watchCycles * 8);
        stopRun("watchdog expired before the program reached its halt");
    end

    initial begin
        i_reset           = 1'b1;
        i_we_IF           = 1'b0;
        i_instAddr        = '0;
        i_instructionData = '0;
        buildProgram();
        watchCycles = 8 + prog.size() + 20 * prog.size();
        repeat (8) @(posedge clk);
        #1;
        i_reset = 1'b0;
        for (int i = 0; i < prog.size(); i++) begin    // load port takes one word a cycle
            i_we_IF           = 1'b1;
            i_instAddr        = i[5:0];
            i_instructionData = prog[i];
            @(posedge clk);
            #1;
        end
        i_we_IF = 1'b0;
        wait (o_end === 1'b1);
        repeat (20) @(posedge clk);   // quiet period after halt
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
